//--- logic/fetch_pkg.sv
// Shared fetch types: address and word widths, trimmed opcodes, link registers

package fetch_pkg;

    //////////////////////////////
    // Widths
    //////////////////////////////
    localparam int XLEN = 32;
    localparam int REG_ADDR_W = 5;

    // Byte address of an instruction
    typedef logic [XLEN-1:0] addr_t;

    // Raw instruction word
    typedef logic [XLEN-1:0] inst_t;

    // Architectural register index
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    //////////////////////////////
    // Opcodes
    //////////////////////////////
    // Bits 6 to 2 of the word, the low two bits are always 2'b11 for RV32
    typedef enum logic [4:0] {
        LOAD_T      = 5'b00000,
        FENCE_T     = 5'b00011,
        ARITH_IMM_T = 5'b00100,
        AUIPC_T     = 5'b00101,
        STORE_T     = 5'b01000,
        AMO_T       = 5'b01011,
        ARITH_T     = 5'b01100,
        LUI_T       = 5'b01101,
        BRANCH_T    = 5'b11000,
        JALR_T      = 5'b11001,
        JAL_T       = 5'b11011,
        SYSTEM_T    = 5'b11100
    } opcode_t;

    //////////////////////////////
    // Calling convention
    //////////////////////////////
    // Return address registers ra and t0
    localparam reg_addr_t LINK_REG_A = 5'd1;
    localparam reg_addr_t LINK_REG_B = 5'd5;

endpackage

//--- logic/fetch.sv
// Fetch unit: program counter, in-flight count, request strobe and redirect handling

`timescale 1ns/1ns

module fetch #(
    parameter fetch_pkg::addr_t RESET_VEC = 32'h0000_0000,
    parameter int FETCH_BUFFER_DEPTH = 4
) (
    input  logic             clk,
    input  logic             rst,

    input  logic             redirect,
    input  fetch_pkg::addr_t redirect_pc,
    input  logic             exception,

    input  logic             mem_data_valid,
    input  logic             ib_pop,

    output logic             mem_request,
    output fetch_pkg::addr_t mem_addr,

    output logic             push,
    output fetch_pkg::addr_t push_pc,
    output logic             buffer_flush
);
    import fetch_pkg::*;

    localparam int COUNT_W = $clog2(FETCH_BUFFER_DEPTH + 1);

    addr_t pc;
    addr_t next_pc;
    addr_t pending_pc;

    logic [COUNT_W-1:0] inflight_count;
    logic space_available;
    logic update_pc;

    //////////////////////////////
    // Redirects
    //////////////////////////////
    assign buffer_flush = redirect | exception;

    //////////////////////////////
    // Request issue
    //////////////////////////////
    // Words requested but not yet popped
    always_ff @(posedge clk) begin
        if (rst | buffer_flush) begin
            inflight_count <= '0;
        end else if (mem_request & ~ib_pop) begin
            inflight_count <= inflight_count + 1'b1;
        end else if (~mem_request & ib_pop) begin
            inflight_count <= inflight_count - 1'b1;
        end
    end

    assign space_available = inflight_count < COUNT_W'(FETCH_BUFFER_DEPTH);

    // Held low through reset, first request in the cycle after release
    assign mem_request = ~rst & space_available & ~buffer_flush;
    assign mem_addr = pc;

    //////////////////////////////
    // Program counter
    //////////////////////////////
    // Exception wins over a branch redirect
    always_comb begin
        if (exception) begin
            next_pc = RESET_VEC;
        end else if (redirect) begin
            next_pc = redirect_pc;
        end else begin
            next_pc = pc + 32'd4;
        end
    end

    assign update_pc = mem_request | buffer_flush;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_VEC;
        end else if (update_pc) begin
            pc <= {next_pc[31:2], 2'b00};
        end
    end

    // Address of the word coming back next cycle
    always_ff @(posedge clk) begin
        if (mem_request) begin
            pending_pc <= pc;
        end
    end

    //////////////////////////////
    // Buffer write
    //////////////////////////////
    // A word landing in a redirect cycle belongs to the old path
    assign push = mem_data_valid & ~buffer_flush;
    assign push_pc = pending_pc;

endmodule

//--- logic/inst_scratch_mem.sv
// Instruction scratch memory: word array with one-cycle read and a load port

`timescale 1ns/1ns

module inst_scratch_mem #(
    parameter int MEM_WORDS = 64
) (
    input  logic             clk,
    input  logic             rst,

    input  logic             mem_request,
    input  fetch_pkg::addr_t mem_addr,

    input  logic             load_en,
    input  fetch_pkg::addr_t load_addr,
    input  fetch_pkg::inst_t load_data,

    output fetch_pkg::inst_t mem_data,
    output logic             mem_data_valid
);
    import fetch_pkg::*;

    localparam int INDEX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    inst_t mem [MEM_WORDS];

    logic [INDEX_W-1:0] read_index;
    logic [INDEX_W-1:0] load_index;

    // Word index, upper address bits wrap around the array
    assign read_index = mem_addr[INDEX_W+1:2];
    assign load_index = load_addr[INDEX_W+1:2];

    // Program load, one word per cycle
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_index] <= load_data;
        end
    end

    // Synchronous read
    always_ff @(posedge clk) begin
        if (mem_request) begin
            mem_data <= mem[read_index];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_data_valid <= 1'b0;
        end else begin
            mem_data_valid <= mem_request;
        end
    end

endmodule

//--- logic/early_decode.sv
// Early decode: register-use flags and call/return detection for a fetched word

`timescale 1ns/1ns

module early_decode (
    input  fetch_pkg::inst_t instruction,

    output logic             uses_rs1,
    output logic             uses_rs2,
    output logic             uses_rd,
    output logic             is_call,
    output logic             is_return
);
    import fetch_pkg::*;

    opcode_t   opcode_trimmed;
    logic [2:0] fn3;
    reg_addr_t rs1_addr;
    reg_addr_t rd_addr;

    logic csr_imm_op;
    logic sys_op;
    logic jump_op;
    logic jump_no_link;
    logic rs1_link;
    logic rd_link;

    //////////////////////////////
    // Field extraction
    //////////////////////////////
    assign opcode_trimmed = opcode_t'(instruction[6:2]);
    assign fn3 = instruction[14:12];
    assign rs1_addr = instruction[19:15];
    assign rd_addr = instruction[11:7];

    // CSR immediate forms take uimm in the rs1 field
    assign csr_imm_op = (opcode_trimmed == SYSTEM_T) && fn3[2];
    // ECALL, EBREAK, MRET and friends
    assign sys_op = (opcode_trimmed == SYSTEM_T) && (fn3 == 3'b000);

    assign jump_op = opcode_trimmed inside {JAL_T, JALR_T};
    assign jump_no_link = jump_op && (rd_addr == '0);

    //////////////////////////////
    // Operand use
    //////////////////////////////
    assign uses_rs1 = !((opcode_trimmed inside {LUI_T, AUIPC_T, JAL_T, FENCE_T})
                        || csr_imm_op || sys_op);

    assign uses_rs2 = opcode_trimmed inside {BRANCH_T, STORE_T, ARITH_T, AMO_T};

    assign uses_rd = !((opcode_trimmed inside {BRANCH_T, STORE_T, FENCE_T})
                       || sys_op || jump_no_link);

    //////////////////////////////
    // Call and return hints
    //////////////////////////////
    assign rs1_link = (rs1_addr == LINK_REG_A) || (rs1_addr == LINK_REG_B);
    assign rd_link = (rd_addr == LINK_REG_A) || (rd_addr == LINK_REG_B);

    assign is_call = jump_op && rd_link;

    // Link to link with the same register is a coroutine swap, not a return
    assign is_return = (opcode_trimmed == JALR_T) && rs1_link
                       && (!rd_link || (rs1_addr != rd_addr));

endmodule

//--- logic/inst_buffer.sv
// Instruction buffer: circular FIFO of fetched words, pcs and decode flags

`timescale 1ns/1ns

module inst_buffer #(
    parameter int FETCH_BUFFER_DEPTH = 4
) (
    input  logic             clk,
    input  logic             rst,

    input  logic             flush,
    input  logic             push,
    input  logic             pop,

    input  fetch_pkg::inst_t push_instruction,
    input  fetch_pkg::addr_t push_pc,
    input  logic [4:0]       push_flags,

    output logic             ib_valid,
    output fetch_pkg::inst_t ib_instruction,
    output fetch_pkg::addr_t ib_pc,
    output logic [4:0]       ib_flags
);
    import fetch_pkg::*;

    localparam int PTR_W = (FETCH_BUFFER_DEPTH > 1) ? $clog2(FETCH_BUFFER_DEPTH) : 1;
    localparam int COUNT_W = $clog2(FETCH_BUFFER_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(FETCH_BUFFER_DEPTH - 1);

    inst_t      inst_mem [FETCH_BUFFER_DEPTH];
    addr_t      pc_mem [FETCH_BUFFER_DEPTH];
    logic [4:0] flag_mem [FETCH_BUFFER_DEPTH];

    logic [PTR_W-1:0] write_ptr;
    logic [PTR_W-1:0] read_ptr;
    logic [COUNT_W-1:0] count;
    logic pop_valid;

    // Empty buffer ignores pops
    assign pop_valid = pop & ib_valid;

    //////////////////////////////
    // Pointers and occupancy
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst | flush) begin
            write_ptr <= '0;
            read_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                write_ptr <= (write_ptr == LAST_SLOT) ? '0 : write_ptr + 1'b1;
            end
            if (pop_valid) begin
                read_ptr <= (read_ptr == LAST_SLOT) ? '0 : read_ptr + 1'b1;
            end
            if (push & ~pop_valid) begin
                count <= count + 1'b1;
            end else if (~push & pop_valid) begin
                count <= count - 1'b1;
            end
        end
    end

    // Entry storage, no full check since fetch bounds requests in flight
    always_ff @(posedge clk) begin
        if (push) begin
            inst_mem[write_ptr] <= push_instruction;
            pc_mem[write_ptr] <= push_pc;
            flag_mem[write_ptr] <= push_flags;
        end
    end

    //////////////////////////////
    // Head of queue
    //////////////////////////////
    assign ib_valid = (count != '0);
    assign ib_instruction = inst_mem[read_ptr];
    assign ib_pc = pc_mem[read_ptr];
    assign ib_flags = flag_mem[read_ptr];

endmodule

//--- logic/fetch_top.sv
// Fetch front end top: fetch unit, scratch memory, early decode and instruction buffer

`timescale 1ns/1ns

module fetch_top #(
    parameter fetch_pkg::addr_t RESET_VEC = 32'h0000_0000,
    parameter int FETCH_BUFFER_DEPTH = 4,
    parameter int MEM_WORDS = 64
) (
    input  logic             clk,
    input  logic             rst,

    input  logic             redirect,
    input  fetch_pkg::addr_t redirect_pc,
    input  logic             exception,

    input  logic             load_en,
    input  fetch_pkg::addr_t load_addr,
    input  fetch_pkg::inst_t load_data,

    input  logic             ib_pop,
    output logic             ib_valid,
    output fetch_pkg::inst_t ib_instruction,
    output fetch_pkg::addr_t ib_pc,
    output logic             ib_uses_rs1,
    output logic             ib_uses_rs2,
    output logic             ib_uses_rd,
    output logic             ib_is_call,
    output logic             ib_is_return
);
    import fetch_pkg::*;

    logic  mem_request;
    addr_t mem_addr;
    inst_t mem_data;
    logic  mem_data_valid;

    logic  push;
    addr_t push_pc;
    logic  buffer_flush;

    logic uses_rs1;
    logic uses_rs2;
    logic uses_rd;
    logic is_call;
    logic is_return;

    // Only pops that the buffer accepts reduce the in-flight count
    fetch #(
        .RESET_VEC          (RESET_VEC),
        .FETCH_BUFFER_DEPTH (FETCH_BUFFER_DEPTH)
    ) fetch_unit (
        .clk            (clk),
        .rst            (rst),
        .redirect       (redirect),
        .redirect_pc    (redirect_pc),
        .exception      (exception),
        .mem_data_valid (mem_data_valid),
        .ib_pop         (ib_pop & ib_valid),
        .mem_request    (mem_request),
        .mem_addr       (mem_addr),
        .push           (push),
        .push_pc        (push_pc),
        .buffer_flush   (buffer_flush)
    );

    inst_scratch_mem #(
        .MEM_WORDS (MEM_WORDS)
    ) scratch_mem (
        .clk            (clk),
        .rst            (rst),
        .mem_request    (mem_request),
        .mem_addr       (mem_addr),
        .load_en        (load_en),
        .load_addr      (load_addr),
        .load_data      (load_data),
        .mem_data       (mem_data),
        .mem_data_valid (mem_data_valid)
    );

    early_decode decode (
        .instruction (mem_data),
        .uses_rs1    (uses_rs1),
        .uses_rs2    (uses_rs2),
        .uses_rd     (uses_rd),
        .is_call     (is_call),
        .is_return   (is_return)
    );

    // Flag order: rs1, rs2, rd, call, return
    inst_buffer #(
        .FETCH_BUFFER_DEPTH (FETCH_BUFFER_DEPTH)
    ) buffer (
        .clk              (clk),
        .rst              (rst),
        .flush            (buffer_flush),
        .push             (push),
        .pop              (ib_pop),
        .push_instruction (mem_data),
        .push_pc          (push_pc),
        .push_flags       ({uses_rs1, uses_rs2, uses_rd, is_call, is_return}),
        .ib_valid         (ib_valid),
        .ib_instruction   (ib_instruction),
        .ib_pc            (ib_pc),
        .ib_flags         ({ib_uses_rs1, ib_uses_rs2, ib_uses_rd, ib_is_call, ib_is_return})
    );

endmodule

//--- verif/fetch_tb.sv
// Testbench for fetch_top: case file reader, program load, random pops, redirects, entry checks

`timescale 1ns/1ns

module fetch_tb;
    import fetch_pkg::*;

    localparam addr_t RESET_VEC = 32'h0000_0000;
    localparam int FETCH_BUFFER_DEPTH = 4;
    localparam int MEM_WORDS = 64;
    localparam int RESET_CYCLES = 2;
    localparam int CYCLES_PER_ENTRY = 20;
    localparam string CASE_FILE = "verif/fetch_cases.txt";

    logic  clk;
    logic  rst;
    logic  redirect;
    addr_t redirect_pc;
    logic  exception;
    logic  load_en;
    addr_t load_addr;
    inst_t load_data;
    logic  ib_pop;
    logic  ib_valid;
    inst_t ib_instruction;
    addr_t ib_pc;
    logic  ib_uses_rs1;
    logic  ib_uses_rs2;
    logic  ib_uses_rd;
    logic  ib_is_call;
    logic  ib_is_return;

    // Program image and expected flags, indexed by word
    inst_t      prog_word [MEM_WORDS];
    logic [4:0] prog_flags [MEM_WORDS];
    logic       prog_known [MEM_WORDS];

    // Redirect events, taken in file order
    addr_t event_pc [$];
    addr_t event_target [$];
    logic  event_is_exc [$];

    int     entry_count;
    int     word_count;
    int     popped;
    int     next_event;
    logic   cases_loaded;
    integer seed;

    fetch_top #(
        .RESET_VEC          (RESET_VEC),
        .FETCH_BUFFER_DEPTH (FETCH_BUFFER_DEPTH),
        .MEM_WORDS          (MEM_WORDS)
    ) dut (
        .clk            (clk),
        .rst            (rst),
        .redirect       (redirect),
        .redirect_pc    (redirect_pc),
        .exception      (exception),
        .load_en        (load_en),
        .load_addr      (load_addr),
        .load_data      (load_data),
        .ib_pop         (ib_pop),
        .ib_valid       (ib_valid),
        .ib_instruction (ib_instruction),
        .ib_pc          (ib_pc),
        .ib_uses_rs1    (ib_uses_rs1),
        .ib_uses_rs2    (ib_uses_rs2),
        .ib_uses_rd     (ib_uses_rd),
        .ib_is_call     (ib_is_call),
        .ib_is_return   (ib_is_return)
    );

    always #50 clk = ~clk;

    //////////////////////////////
    // Helpers
    //////////////////////////////
    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            fail_run($sformatf("[ERROR] %s: expected 0x%h, got 0x%h", name, expected, got));
        end
    endtask

    // Word slot in the scratch memory
    function automatic int word_index(input addr_t addr);
        return int'(addr[31:2] % MEM_WORDS);
    endfunction

    task automatic read_cases();
        int    fd;
        int    fields;
        int    idx;
        int    f_rs1;
        int    f_rs2;
        int    f_rd;
        int    f_call;
        int    f_ret;
        string line;
        string rest;
        addr_t addr;
        addr_t target;
        inst_t word;
        for (int i = 0; i < MEM_WORDS; i++) begin
            prog_known[i] = 1'b0;
        end
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            fail_run({"Could not open the case file ", CASE_FILE});
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 3 || line.getc(0) == "#") begin
                continue;
            end
            rest = line.substr(2, line.len() - 1);
            case (line.getc(0))
                "W": begin
                    fields = $sscanf(rest, "%h %h %d %d %d %d %d",
                                     addr, word, f_rs1, f_rs2, f_rd, f_call, f_ret);
                    assert (fields == 7) else fail_run({"Malformed program line: ", line});
                    idx = word_index(addr);
                    prog_word[idx] = word;
                    prog_flags[idx] = {f_rs1[0], f_rs2[0], f_rd[0], f_call[0], f_ret[0]};
                    prog_known[idx] = 1'b1;
                    word_count++;
                end
                "J": begin
                    fields = $sscanf(rest, "%h %h", addr, target);
                    assert (fields == 2) else fail_run({"Malformed redirect line: ", line});
                    event_pc.push_back(addr);
                    event_target.push_back(target);
                    event_is_exc.push_back(1'b0);
                end
                "E": begin
                    fields = $sscanf(rest, "%h", addr);
                    assert (fields == 1) else fail_run({"Malformed exception line: ", line});
                    event_pc.push_back(addr);
                    event_target.push_back(RESET_VEC);
                    event_is_exc.push_back(1'b1);
                end
                "C": begin
                    fields = $sscanf(rest, "%d", entry_count);
                    assert (fields == 1) else fail_run({"Malformed count line: ", line});
                end
                default: fail_run({"Unknown line kind in the case file: ", line});
            endcase
        end
        $fclose(fd);
    endtask

    // Writes the program through the load port, one word per cycle
    task automatic load_program();
        for (int i = 0; i < MEM_WORDS; i++) begin
            if (prog_known[i]) begin
                @(posedge clk);
                load_en <= 1'b1;
                load_addr <= addr_t'(i * 4);
                load_data <= prog_word[i];
            end
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    task automatic check_entry(input addr_t exp_pc);
        int idx;
        idx = word_index(exp_pc);
        assert (prog_known[idx]) else begin
            fail_run($sformatf("No program word in the case file for pc 0x%h", exp_pc));
        end
        check_value("ib_pc", ib_pc, exp_pc);
        check_value("ib_instruction", ib_instruction, prog_word[idx]);
        check_value("ib_uses_rs1", {31'b0, ib_uses_rs1}, {31'b0, prog_flags[idx][4]});
        check_value("ib_uses_rs2", {31'b0, ib_uses_rs2}, {31'b0, prog_flags[idx][3]});
        check_value("ib_uses_rd", {31'b0, ib_uses_rd}, {31'b0, prog_flags[idx][2]});
        check_value("ib_is_call", {31'b0, ib_is_call}, {31'b0, prog_flags[idx][1]});
        check_value("ib_is_return", {31'b0, ib_is_return}, {31'b0, prog_flags[idx][0]});
    endtask

    //////////////////////////////
    // Stimulus and checking
    //////////////////////////////
    initial begin : stimulus
        addr_t       model_pc;
        addr_t       target_now;
        logic [31:0] rand_val;
        logic        pop_now;
        logic        pop_last;
        logic        redirect_now;
        logic        exception_now;
        clk = 1'b0;
        rst = 1'b1;
        redirect = 1'b0;
        redirect_pc = '0;
        exception = 1'b0;
        load_en = 1'b0;
        load_addr = '0;
        load_data = '0;
        ib_pop = 1'b0;
        seed = 32'h97b5;
        popped = 0;
        next_event = 0;
        word_count = 0;
        entry_count = 0;
        cases_loaded = 1'b0;

        read_cases();
        cases_loaded = 1'b1;

        // Program goes in while fetch is held in reset
        repeat (RESET_CYCLES) @(posedge clk);
        load_program();
        @(posedge clk);
        rst <= 1'b0;

        // First request right after release, its entry shows two cycles later
        repeat (2) begin
            @(negedge clk);
            check_value("ib_valid", {31'b0, ib_valid}, 32'h0);
        end
        @(negedge clk);
        check_value("ib_valid", {31'b0, ib_valid}, 32'h1);

        model_pc = RESET_VEC;
        pop_last = 1'b0;
        while (popped < entry_count) begin
            @(negedge clk);
            rand_val = $random(seed);
            pop_now = 1'b0;
            redirect_now = 1'b0;
            exception_now = 1'b0;
            target_now = '0;
            // Head holds still into the next cycle only when nothing pops in this one
            if (ib_valid && !pop_last && (rand_val % 32'd10) < 32'd6) begin
                check_entry(model_pc);
                pop_now = 1'b1;
                popped++;
                if (next_event < event_pc.size() && event_pc[next_event] == model_pc) begin
                    redirect_now = !event_is_exc[next_event];
                    exception_now = event_is_exc[next_event];
                    target_now = event_target[next_event];
                    model_pc = event_is_exc[next_event] ? RESET_VEC : event_target[next_event];
                    next_event++;
                end else begin
                    model_pc = model_pc + 32'd4;
                end
            end
            pop_last = pop_now;
            @(posedge clk);
            ib_pop <= pop_now;
            redirect <= redirect_now;
            exception <= exception_now;
            redirect_pc <= target_now;
        end
        @(posedge clk);
        ib_pop <= 1'b0;
        redirect <= 1'b0;
        exception <= 1'b0;

        if (next_event == event_pc.size()) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            fail_run($sformatf("Only %0d of %0d redirect events were reached",
                               next_event, event_pc.size()));
        end
    end

    // Allowance per entry plus reset and program load
    initial begin : watchdog
        int limit;
        wait (cases_loaded === 1'b1);
        limit = entry_count * CYCLES_PER_ENTRY + word_count + RESET_CYCLES + 2;
        repeat (limit) @(posedge clk);
        fail_run($sformatf("Timeout, entries stopped arriving after %0d of %0d",
                           popped, entry_count));
    end

endmodule

//--- src.f
logic/fetch_pkg.sv
logic/fetch.sv
logic/inst_scratch_mem.sv
logic/early_decode.sv
logic/inst_buffer.sv
logic/fetch_top.sv
verif/fetch_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = fetch_tb
FILELIST  = src.f
BUILD_DIR = obj_dir
LOG       = sim.log

SOURCES   = $(shell cat $(FILELIST))
SIM_BIN   = $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/fetch_cases.txt
# W addr word uses_rs1 uses_rs2 uses_rd is_call is_return (hex address and word)
# J popped_pc target, E popped_pc, C number of entries to check
W 00000000 00010137 0 0 1 0 0
W 00000004 01010113 1 0 1 0 0
W 00000008 00000197 0 0 1 0 0
W 0000000c 00310233 1 1 1 0 0
W 00000010 00412023 1 1 0 0 0
W 00000014 00412283 1 0 1 0 0
W 00000018 020000ef 0 0 1 1 0
W 0000001c 00520463 1 1 0 0 0
W 00000020 0ff0000f 0 0 0 0 0
W 00000024 00000073 0 0 0 0 0
W 00000028 34039373 1 0 1 0 0
W 0000002c 3402d073 0 0 1 0 0
W 00000030 ff1ff06f 0 0 0 0 0
W 00000034 0095242f 1 1 1 0 0
W 00000038 ff010113 1 0 1 0 0
W 0000003c 00112623 1 1 0 0 0
W 00000040 000302e7 1 0 1 1 0
W 00000044 00008067 1 0 0 0 1
W 00000048 000280e7 1 0 1 1 1
W 0000004c 000080e7 1 0 1 1 0
W 00000050 40d605b3 1 1 1 0 0
W 00000054 00100073 0 0 0 0 0
W 00000058 30002773 1 0 1 0 0
W 0000005c 008002ef 0 0 1 1 0
W 00000060 fff80783 1 0 1 0 0
W 00000064 00106893 1 0 1 0 0
# Call into the subroutine, return, loop jump, exception, far jump, call over 0x60
J 00000018 00000038
J 00000044 0000001c
J 00000030 00000020
E 00000024
J 0000000c 00000034
J 0000005c 00000064
C 35
